/* src/xpipe_params.svh */
/*
  xpipe widths and multiplier timing
  Tag, data and register address sizes shared by the package and units
*/

`ifndef XPIPE_PARAMS_SVH
`define XPIPE_PARAMS_SVH

// Sequence tag, 32 ops in flight
`define XPIPE_SEQ_BITS 5

// Operand and result width
`define XPIPE_DATA_BITS 32

// Destination register address
`define XPIPE_REG_BITS 5

// One multiplier iteration per operand bit
`define XPIPE_MUL_CYCLES `XPIPE_DATA_BITS

`endif

/* src/xpipe_pkg.sv */
/*
  xpipe types
  Opcode encoding plus the issue and writeback payloads
*/

`include "xpipe_params.svh"

package xpipe_pkg;

  // --------------------
  // Opcodes
  // --------------------

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLT   = 4'd5,
    OP_SLTU  = 4'd6,
    OP_SLL   = 4'd7,
    OP_SRL   = 4'd8,
    OP_SRA   = 4'd9,
    OP_MUL   = 4'd10,
    OP_MULHU = 4'd11
  } op_e;

  // --------------------
  // Payloads
  // --------------------

  // Issue side, 78 bits
  typedef struct packed {
    op_e                         op;
    logic [`XPIPE_SEQ_BITS-1:0]  seq;
    logic [`XPIPE_REG_BITS-1:0]  waddr;
    logic [`XPIPE_DATA_BITS-1:0] op_a;
    logic [`XPIPE_DATA_BITS-1:0] op_b;
  } issue_t;

  // Writeback side, 42 bits
  typedef struct packed {
    logic [`XPIPE_SEQ_BITS-1:0]  seq;
    logic [`XPIPE_REG_BITS-1:0]  waddr;
    logic [`XPIPE_DATA_BITS-1:0] wdata;
  } wb_t;

endpackage

/* src/xpipe_alu.sv */
/*
  xpipe ALU execute unit
  Single-cycle RV32I register-register ops, result held until granted
*/

`timescale 1ns/1ps

`include "xpipe_params.svh"

module xpipe_alu (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_val,
  input  xpipe_pkg::issue_t  issue,
  output logic               busy,
  output logic               req,
  output xpipe_pkg::wb_t     res,
  input  logic               gnt
);

  logic                         is_alu;
  logic [4:0]                   shamt;
  logic [`XPIPE_DATA_BITS-1:0]  alu_out;

  // Everything except the multiply class
  assign is_alu = (issue.op != xpipe_pkg::OP_MUL) && (issue.op != xpipe_pkg::OP_MULHU);
  assign shamt  = issue.op_b[4:0];

  // --------------------
  // Datapath
  // --------------------

  always_comb begin
    case (issue.op)
      xpipe_pkg::OP_ADD:  alu_out = issue.op_a + issue.op_b;
      xpipe_pkg::OP_SUB:  alu_out = issue.op_a - issue.op_b;
      xpipe_pkg::OP_AND:  alu_out = issue.op_a & issue.op_b;
      xpipe_pkg::OP_OR:   alu_out = issue.op_a | issue.op_b;
      xpipe_pkg::OP_XOR:  alu_out = issue.op_a ^ issue.op_b;
      // Compares give 1 or 0
      xpipe_pkg::OP_SLT:  alu_out = {31'b0, $signed(issue.op_a) < $signed(issue.op_b)};
      xpipe_pkg::OP_SLTU: alu_out = {31'b0, issue.op_a < issue.op_b};
      xpipe_pkg::OP_SLL:  alu_out = issue.op_a << shamt;
      xpipe_pkg::OP_SRL:  alu_out = issue.op_a >> shamt;
      xpipe_pkg::OP_SRA:  alu_out = $unsigned($signed(issue.op_a) >>> shamt);
      default:            alu_out = '0;
    endcase
  end

  // --------------------
  // Hold register
  // --------------------

  // Set on accept, cleared by grant
  always_ff @(posedge clk) begin
    if (rst) begin
      req <= 1'b0;
    end else if (issue_val && is_alu) begin
      req <= 1'b1;
    end else if (gnt) begin
      req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_val && is_alu) begin
      res.seq   <= issue.seq;
      res.waddr <= issue.waddr;
      res.wdata <= alu_out;
    end
  end

  // Free again the cycle after grant
  assign busy = req;

endmodule

/* src/xpipe_mul.sv */
/*
  xpipe multiplier execute unit
  Unsigned shift-add, one operand bit per cycle, MUL or MULHU word out
*/

`timescale 1ns/1ps

`include "xpipe_params.svh"

module xpipe_mul (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_val,
  input  xpipe_pkg::issue_t  issue,
  output logic               busy,
  output logic               req,
  output xpipe_pkg::wb_t     res,
  input  logic               gnt
);

  localparam int CNT_BITS = $clog2(`XPIPE_MUL_CYCLES + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HOLD} state_e;

  state_e                         state;
  logic [CNT_BITS-1:0]            cnt;
  logic                           is_mul;
  logic                           start;
  logic                           hi_sel;
  logic [2*`XPIPE_DATA_BITS-1:0]  mcand;
  logic [2*`XPIPE_DATA_BITS-1:0]  acc;
  logic [`XPIPE_DATA_BITS-1:0]    mplier;

  assign is_mul = (issue.op == xpipe_pkg::OP_MUL) || (issue.op == xpipe_pkg::OP_MULHU);
  // Only accepted when idle
  assign start  = issue_val && is_mul && (state == ST_IDLE);

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          state <= ST_RUN;
          cnt   <= CNT_BITS'(`XPIPE_MUL_CYCLES);
        end
        // Extra cycle at zero count picks the result word
        ST_RUN: if (cnt == '0) state <= ST_HOLD;
                else cnt <= cnt - 1'b1;
        ST_HOLD: if (gnt) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // Shift-add datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (start) begin
      mcand     <= {{`XPIPE_DATA_BITS{1'b0}}, issue.op_a};
      mplier    <= issue.op_b;
      acc       <= '0;
      hi_sel    <= (issue.op == xpipe_pkg::OP_MULHU);
      res.seq   <= issue.seq;
      res.waddr <= issue.waddr;
    end else if (state == ST_RUN) begin
      if (cnt != '0) begin
        // Add shifted multiplicand where the multiplier bit is set
        if (mplier[0]) acc <= acc + mcand;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end else begin
        res.wdata <= hi_sel ? acc[2*`XPIPE_DATA_BITS-1:`XPIPE_DATA_BITS]
                            : acc[`XPIPE_DATA_BITS-1:0];
      end
    end
  end

  assign req  = (state == ST_HOLD);
  assign busy = (state != ST_IDLE);

endmodule

/* src/xpipe_wb_arb.sv */
/*
  xpipe writeback arbiter
  Two-way round robin onto the shared writeback bus, registered completion
*/

`timescale 1ns/1ps

module xpipe_wb_arb (
  input  logic            clk,
  input  logic            rst,
  input  logic            alu_req,
  input  xpipe_pkg::wb_t  alu_res,
  input  logic            mul_req,
  input  xpipe_pkg::wb_t  mul_res,
  output logic            alu_gnt,
  output logic            mul_gnt,
  output logic            complete_val,
  output xpipe_pkg::wb_t  complete
);

  // Priority pointer, 0 favours the ALU
  logic            prio_mul;
  logic            contend;
  xpipe_pkg::wb_t  wb_bus;

  assign contend = alu_req && mul_req;

  // --------------------
  // Grant
  // --------------------

  assign alu_gnt = alu_req && (!mul_req || !prio_mul);
  assign mul_gnt = mul_req && (!alu_req || prio_mul);

  // Flip only when both asked
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_mul <= 1'b0;
    end else if (contend) begin
      prio_mul <= ~prio_mul;
    end
  end

  // --------------------
  // Writeback bus
  // --------------------

  assign wb_bus = mul_gnt ? mul_res : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      complete_val <= 1'b0;
    end else begin
      complete_val <= alu_gnt || mul_gnt;
    end
  end

  // Payload follows the granted unit
  always_ff @(posedge clk) begin
    if (alu_gnt || mul_gnt) complete <= wb_bus;
  end

endmodule

/* src/xpipe_top.sv */
/*
  xpipe execute and writeback slice
  ALU and multiplier sharing one writeback bus through a round-robin arbiter
*/

`timescale 1ns/1ps

module xpipe_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_val,
  input  xpipe_pkg::issue_t  issue,
  output logic               alu_busy,
  output logic               mul_busy,
  output logic               complete_val,
  output xpipe_pkg::wb_t     complete
);

  // Unit to arbiter
  logic            alu_req;
  logic            mul_req;
  logic            alu_gnt;
  logic            mul_gnt;
  xpipe_pkg::wb_t  alu_res;
  xpipe_pkg::wb_t  mul_res;

  // --------------------
  // Execute units
  // --------------------

  // Issue strobe goes to both, each filters its own class
  xpipe_alu u_alu (
    .clk       (clk),
    .rst       (rst),
    .issue_val (issue_val),
    .issue     (issue),
    .busy      (alu_busy),
    .req       (alu_req),
    .res       (alu_res),
    .gnt       (alu_gnt)
  );

  xpipe_mul u_mul (
    .clk       (clk),
    .rst       (rst),
    .issue_val (issue_val),
    .issue     (issue),
    .busy      (mul_busy),
    .req       (mul_req),
    .res       (mul_res),
    .gnt       (mul_gnt)
  );

  // --------------------
  // Writeback
  // --------------------

  xpipe_wb_arb u_wb_arb (
    .clk          (clk),
    .rst          (rst),
    .alu_req      (alu_req),
    .alu_res      (alu_res),
    .mul_req      (mul_req),
    .mul_res      (mul_res),
    .alu_gnt      (alu_gnt),
    .mul_gnt      (mul_gnt),
    .complete_val (complete_val),
    .complete     (complete)
  );

endmodule

/* tb/xpipe_clk_gen.sv */
/*
  xpipe testbench clock
  Free-running clock, 40 ns period
*/

`timescale 1ns/1ps

module xpipe_clk_gen #(
  parameter int HALF_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #HALF_NS clk = ~clk;

endmodule

/* tb/xpipe_chk.sv */
/*
  xpipe port checker
  Bound to the top level, flags issue to a busy unit and bad completions
*/

`timescale 1ns/1ps

module xpipe_chk (
  input logic               clk,
  input logic               rst,
  input logic               issue_val,
  input xpipe_pkg::issue_t  issue,
  input logic               alu_busy,
  input logic               mul_busy,
  input logic               complete_val,
  input xpipe_pkg::wb_t     complete
);

  logic to_mul;

  // Multiply class, everything else goes to the ALU
  assign to_mul = (issue.op == xpipe_pkg::OP_MUL) || (issue.op == xpipe_pkg::OP_MULHU);

  // --------------------
  // Issue rules
  // --------------------

  a_alu_idle: assert property (@(posedge clk) disable iff (rst)
    issue_val && !to_mul |-> !alu_busy)
    else $error("ALU op issued while the ALU is busy");

  a_mul_idle: assert property (@(posedge clk) disable iff (rst)
    issue_val && to_mul |-> !mul_busy)
    else $error("Multiply issued while the multiplier is busy");

  // --------------------
  // Completion rules
  // --------------------

  // Cleared by the first reset edge, low for the rest of reset
  a_quiet_in_reset: assert property (@(posedge clk)
    rst |=> !complete_val)
    else $error("Completion strobe high during reset");

  a_seq_known: assert property (@(posedge clk) disable iff (rst)
    complete_val |-> !$isunknown(complete.seq))
    else $error("Completion tag has unknown bits");

endmodule

/* tb/xpipe_tb.sv */
/*
  xpipe testbench
  Issues pattern ops to both units, scores completions by tag
*/

`timescale 1ns/1ps

`include "xpipe_params.svh"

module xpipe_tb;

  localparam int NUM_PATS   = 28;
  // Two contention rounds of two ops each follow the patterns
  localparam int NUM_OPS    = NUM_PATS + 4;
  localparam int TAGS       = 1 << `XPIPE_SEQ_BITS;
  localparam int MAX_CYCLES = NUM_OPS * (`XPIPE_MUL_CYCLES + 8) + 100;

  logic               clk;
  logic               rst;
  logic               issue_val;
  xpipe_pkg::issue_t  issue;
  logic               alu_busy;
  logic               mul_busy;
  logic               complete_val;
  xpipe_pkg::wb_t     complete;

  // Entry layout: op, waddr, op_a, op_b, expected
  logic [107:0]                 pat_mem [NUM_PATS];
  // Scoreboard, outstanding while the two counts differ
  logic [`XPIPE_REG_BITS-1:0]   exp_waddr [TAGS];
  logic [`XPIPE_DATA_BITS-1:0]  exp_wdata [TAGS];
  int                           issue_cnt [TAGS] = '{default: 0};
  int                           done_cnt [TAGS] = '{default: 0};
  // Cycle of the latest completion per tag
  int                           done_cycle [TAGS] = '{default: 0};
  int                           done_total = 0;
  int                           cycle_count = 0;
  logic [31:0]                  rng;

  xpipe_clk_gen u_clk_gen (.clk(clk));

  xpipe_top u_xpipe_top (
    .clk          (clk),
    .rst          (rst),
    .issue_val    (issue_val),
    .issue        (issue),
    .alu_busy     (alu_busy),
    .mul_busy     (mul_busy),
    .complete_val (complete_val),
    .complete     (complete)
  );

  bind xpipe_top xpipe_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .issue_val    (issue_val),
    .issue        (issue),
    .alu_busy     (alu_busy),
    .mul_busy     (mul_busy),
    .complete_val (complete_val),
    .complete     (complete)
  );

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Waits for the target unit and a free tag, then strobes one entry
  task automatic issue_entry(input int idx, input int seq_num);
    xpipe_pkg::op_e              op;
    logic                        to_mul;
    logic [`XPIPE_SEQ_BITS-1:0]  tag;
    op     = xpipe_pkg::op_e'(pat_mem[idx][107:104]);
    to_mul = (op == xpipe_pkg::OP_MUL) || (op == xpipe_pkg::OP_MULHU);
    tag    = seq_num[`XPIPE_SEQ_BITS-1:0];
    while ((to_mul ? mul_busy : alu_busy) || (issue_cnt[tag] != done_cnt[tag])) begin
      @(posedge clk);
      #2;
    end
    exp_waddr[tag] = pat_mem[idx][100:96];
    exp_wdata[tag] = pat_mem[idx][31:0];
    issue_cnt[tag] = issue_cnt[tag] + 1;
    issue_val   = 1'b1;
    issue.op    = op;
    issue.seq   = tag;
    issue.waddr = pat_mem[idx][100:96];
    issue.op_a  = pat_mem[idx][95:64];
    issue.op_b  = pat_mem[idx][63:32];
    @(posedge clk);
    #2;
    issue_val = 1'b0;
    // Accepting unit goes busy on the issue edge
    if (to_mul) begin
      check_val("mul_busy", 32'(mul_busy), 32'h1);
    end else begin
      check_val("alu_busy", 32'(alu_busy), 32'h1);
    end
  endtask

  // ALU result held in the very cycle the product becomes ready
  task automatic contend_round(input int mul_idx, input int alu_idx, input int seq_num,
                               output logic mul_won);
    int mul_tag;
    int alu_tag;
    mul_tag = seq_num % TAGS;
    alu_tag = (seq_num + 1) % TAGS;
    issue_entry(mul_idx, mul_tag);
    // Product ready XPIPE_MUL_CYCLES + 1 edges after the issue edge
    repeat (`XPIPE_MUL_CYCLES) begin
      @(posedge clk);
      #2;
    end
    issue_entry(alu_idx, alu_tag);
    while ((issue_cnt[mul_tag] != done_cnt[mul_tag]) ||
           (issue_cnt[alu_tag] != done_cnt[alu_tag])) begin
      @(posedge clk);
      #2;
    end
    mul_won = done_cycle[mul_tag] < done_cycle[alu_tag];
  endtask

  // --------------------
  // Issue side
  // --------------------

  initial begin
    int    idx;
    int    gap;
    logic  first_mul_won;
    logic  second_mul_won;
    rst       = 1'b1;
    issue_val = 1'b0;
    issue     = '0;
    rng       = 32'h02993c20;
    $readmemh("tb/xpipe_patterns.hex", pat_mem);
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    for (idx = 0; idx < NUM_PATS; idx++) begin
      issue_entry(idx, idx);
      // Idle gap of 0 to 3 cycles
      rng = next_rand(rng);
      gap = int'(rng[1:0]);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end
    // Entry 22 is a MUL, 19 a MULHU, 0 and 1 are ALU ops
    contend_round(22, 0, NUM_PATS, first_mul_won);
    contend_round(19, 1, NUM_PATS + 2, second_mul_won);
    if (first_mul_won == second_mul_won) begin
      fail_run("Arbiter did not alternate between contending ALU and multiplier results");
    end
    while (done_total < NUM_OPS) @(posedge clk);
    #2;
    // Both units idle once everything has drained
    check_val("alu_busy", 32'(alu_busy), 32'h0);
    check_val("mul_busy", 32'(mul_busy), 32'h0);
    $display("SIMULATION PASSED");
    $finish;
  end

  // --------------------
  // Completion side
  // --------------------

  // Checked by tag, order follows readiness
  always @(negedge clk) begin
    if (!rst && complete_val) begin
      if (issue_cnt[complete.seq] == done_cnt[complete.seq]) begin
        fail_run($sformatf("Completion for seq %0d arrived with no op outstanding under it",
                           complete.seq));
      end
      check_val("complete.waddr", 32'(complete.waddr), 32'(exp_waddr[complete.seq]));
      check_val("complete.wdata", complete.wdata, exp_wdata[complete.seq]);
      done_cnt[complete.seq] = done_cnt[complete.seq] + 1;
      done_cycle[complete.seq] = cycle_count;
      done_total = done_total + 1;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results missing",
                         cycle_count, NUM_OPS - done_total, NUM_OPS));
    end
  end

endmodule

/* xpipe.f */
+incdir+src
src/xpipe_pkg.sv
src/xpipe_alu.sv
src/xpipe_mul.sv
src/xpipe_wb_arb.sv
src/xpipe_top.sv
tb/xpipe_clk_gen.sv
tb/xpipe_chk.sv
tb/xpipe_tb.sv

/* Makefile */
# Verilator build and run for the xpipe slice

VERILATOR ?= verilator
TOP       ?= xpipe_tb
FILELIST  ?= xpipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= SIMULATION PASSED

SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv tb/*.hex)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The pass string in the log decides the exit status
run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/xpipe_patterns.hex */
// Columns: op (0 ADD .. 9 SRA, A MUL, B MULHU), waddr, op_a, op_b, expected wdata
// Each line is one issue entry in order, fields split by underscores
0_01_00000005_00000003_00000008
1_02_00000003_00000005_FFFFFFFE
A_03_00000000_12345678_00000000
2_04_F0F0F0F0_0FF00FF0_00F000F0
3_05_F0F0F0F0_0F0F0000_FFFFF0F0
4_06_AAAA5555_FFFF0000_55555555
5_07_FFFFFFFF_00000001_00000001
B_08_FFFFFFFF_FFFFFFFF_FFFFFFFE
6_09_FFFFFFFF_00000001_00000000
7_0A_00000001_00000024_00000010
8_0B_80000000_0000001F_00000001
9_0C_80000000_00000004_F8000000
A_0D_00000001_DEADBEEF_DEADBEEF
0_0E_FFFFFFFF_00000001_00000000
1_0F_00000000_00000001_FFFFFFFF
B_10_00000001_DEADBEEF_00000000
5_11_00000005_FFFFFFFB_00000000
A_12_FFFFFFFF_FFFFFFFF_00000001
4_13_12345678_12345678_00000000
B_14_DEADBEEF_00000100_000000DE
2_15_FFFFFFFF_00000000_00000000
9_16_7FFFFFF0_00000004_07FFFFFF
A_17_00003039_0000D431_27F86EE9
6_18_00000001_FFFFFFFF_00000001
7_19_FFFFFFFF_0000001F_80000000
A_1A_DEADBEEF_00000100_ADBEEF00
0_1B_7FFFFFFF_7FFFFFFF_FFFFFFFE
8_1C_FFFFFFFF_00000000_FFFFFFFF
